/* Makefile */
TOP = mips_tb

all: sim

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP)
	./obj_dir/V$(TOP) +verilator+error+limit+100 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Test failures found" sim.log; then exit 1; fi
	@grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all lint sim clean

/* bench/mips_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_tb;

    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    logic            clk;
    logic            rst_n;
    imem_load_t      load;
    wb_t             wb;
    logic [XLEN-1:0] pc;

    logic [XLEN-1:0] prog [$];                        // Program words
    wb_t             exp_wb [$];                      // Expected writes, in program order
    logic [XLEN-1:0] shadow [0:31];                   // ISA-level register state
    logic [XLEN-1:0] shadow_mem [0:(1<<DMEM_AW)-1];
    logic [XLEN-1:0] halt_pc;
    logic            prog_ready = 1'b0;
    int              skip_cnt;
    int              n_checks;
    int              n_errors;

    mips_top UUT (
        .i_clk   (clk),
        .i_rst_n (rst_n),
        .i_load  (load),
        .o_wb    (wb),
        .o_pc    (pc)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Program builder with a sequential ISA model
    //////////////////////////////////////////////////////////////////////

    task automatic retire(input logic [REG_AW-1:0] rd, input logic [XLEN-1:0] val);
        wb_t w;
        if (rd != '0) begin  // r0 never retires
            shadow[rd] = val;
            w.we   = 1'b1;
            w.dest = rd;
            w.data = val;
            exp_wb.push_back(w);
        end
    endtask

    task automatic emit_r(input funct_e f, input logic [REG_AW-1:0] rd,
                          input logic [REG_AW-1:0] rs, input logic [REG_AW-1:0] rt);
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] b;
        logic [XLEN-1:0] y;
        prog.push_back({OP_RTYPE, rs, rt, rd, 5'd0, f});
        a = shadow[rs];
        b = shadow[rt];
        case (f)
            F_ADD:   y = a + b;
            F_SUB:   y = a - b;
            F_AND:   y = a & b;
            F_OR:    y = a | b;
            default: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
        if (skip_cnt > 0) begin
            skip_cnt--;  // Shadowed by a taken beq
        end else begin
            retire(rd, y);
        end
    endtask

    task automatic emit_i(input opcode_e op, input logic [REG_AW-1:0] rt,
                          input logic [REG_AW-1:0] rs, input logic [15:0] imm);
        logic [XLEN-1:0] ea;
        prog.push_back({op, rs, rt, imm});
        ea = shadow[rs] + {{16{imm[15]}}, imm};
        if (skip_cnt > 0) begin
            skip_cnt--;
        end else begin
            case (op)
                OP_ADDI: retire(rt, ea);
                OP_LW:   retire(rt, shadow_mem[ea[DMEM_AW+1:2]]);
                OP_SW:   shadow_mem[ea[DMEM_AW+1:2]] = shadow[rt];
                OP_BEQ: begin
                    if (shadow[rs] == shadow[rt]) begin
                        skip_cnt = int'($signed(imm));
                    end
                end
                default: ;
            endcase
        end
    endtask

    task automatic build_program();
        logic [15:0] v1;
        logic [15:0] v2;
        logic [15:0] v3;
        v1 = 16'($urandom);
        v2 = v1;
        while (v2 == v1) begin
            v2 = 16'($urandom);  // Keeps the second beq not taken
        end
        v3 = 16'($urandom);
        // ALU ops on random values, dependents at distance one and two
        emit_i(OP_ADDI, 5'd1, 5'd0, v1);
        emit_i(OP_ADDI, 5'd2, 5'd0, v2);
        emit_r(F_ADD, 5'd3, 5'd1, 5'd2);
        emit_r(F_SUB, 5'd4, 5'd3, 5'd1);
        emit_r(F_AND, 5'd5, 5'd1, 5'd2);
        emit_r(F_OR,  5'd6, 5'd5, 5'd4);
        emit_r(F_SLT, 5'd7, 5'd1, 5'd2);
        emit_r(F_SLT, 5'd8, 5'd2, 5'd1);
        emit_i(OP_ADDI, 5'd9, 5'd1, 16'd5);
        emit_i(OP_ADDI, 5'd9, 5'd9, 16'd7);
        emit_r(F_ADD, 5'd10, 5'd9, 5'd9);
        // Load-use, one with forwarded store data
        emit_i(OP_SW, 5'd3, 5'd0, 16'd8);
        emit_i(OP_LW, 5'd11, 5'd0, 16'd8);
        emit_r(F_ADD, 5'd12, 5'd11, 5'd2);
        emit_i(OP_ADDI, 5'd13, 5'd0, v3);
        emit_i(OP_SW, 5'd13, 5'd0, 16'd12);
        emit_i(OP_LW, 5'd14, 5'd0, 16'd12);
        emit_r(F_SUB, 5'd15, 5'd14, 5'd1);
        // Taken beq over three writes, then a not-taken one
        emit_i(OP_BEQ, 5'd1, 5'd1, 16'd3);
        emit_i(OP_ADDI, 5'd20, 5'd0, 16'd1);
        emit_i(OP_ADDI, 5'd21, 5'd0, 16'd2);
        emit_i(OP_ADDI, 5'd22, 5'd0, 16'd3);
        emit_i(OP_ADDI, 5'd23, 5'd0, 16'd4);
        emit_i(OP_BEQ, 5'd2, 5'd1, 16'd3);
        emit_i(OP_ADDI, 5'd24, 5'd0, 16'd5);
        emit_i(OP_ADDI, 5'd25, 5'd24, 16'd1);
        // r0 stays zero
        emit_i(OP_ADDI, 5'd0, 5'd0, 16'd77);
        emit_r(F_ADD, 5'd26, 5'd0, 5'd1);
        halt_pc = XLEN'(prog.size() * 4);
        prog.push_back({OP_BEQ, 5'd0, 5'd0, 16'hffff});  // Loops on itself
        repeat (3) begin
            prog.push_back('0);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////////////////////////

    task automatic check_wb(input wb_t got, input wb_t want, input int idx);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("Mismatch o_wb write %0d: got dest %h data %h, expected dest %h data %h",
                     idx, got.dest, got.data, want.dest, want.data);
        end else begin
            $display("Write %0d: r%0d = %h", idx, got.dest, got.data);
        end
    endtask

    task automatic check_pc(input logic [XLEN-1:0] got, input logic [XLEN-1:0] want);
        n_checks++;
        if (got !== want) begin
            n_errors++;
            $display("Mismatch o_pc: got %h expected %h", got, want);
        end else begin
            $display("Halt loop at pc %h", got);
        end
    endtask

    initial begin
        int              n;
        logic [XLEN-1:0] low_pc;
        void'($urandom(39));
        rst_n     = 1'b0;
        load      = '0;
        skip_cnt  = 0;
        n_checks  = 0;
        n_errors  = 0;
        shadow[0] = '0;
        build_program();
        prog_ready = 1'b1;
        for (int k = 0; k < prog.size(); k++) begin
            @(negedge clk);
            load.we   = 1'b1;
            load.addr = IMEM_AW'(k);
            load.data = prog[k];
        end
        @(negedge clk);
        load.we = 1'b0;
        repeat (5) @(negedge clk);  // Reset held 5 more cycles
        rst_n = 1'b1;
        n = 0;
        while (n < exp_wb.size()) begin
            @(negedge clk);
            if (wb.we) begin
                check_wb(wb, exp_wb[n], n);
                n++;
            end
        end
        // Halt loop runs through H..H+12, nothing may retire
        low_pc = '1;
        repeat (12) begin
            @(negedge clk);
            if (wb.we) begin
                n_errors++;
                $display("Unexpected write to r%0d after the last expected write", wb.dest);
            end
            if (pc < low_pc) begin
                low_pc = pc;
            end
        end
        check_pc(low_pc, halt_pc);
        n_errors += UUT.u_decode.u_props.fail_count;
        $display("Summary: %0d checks, %0d errors", n_checks, n_errors);
        if (n_errors == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

    // Watchdog
    initial begin
        wait (prog_ready);
        repeat (20 * prog.size() + 100) @(posedge clk);
        $display("Timeout: expected writes did not all retire in time");
        $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

/* bench/mips_tb_properties.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_tb_properties (
    input wire logic                 i_clk,
    input wire logic                 i_rst_n,
    input wire logic                 i_stall,
    input wire mips_pipe_pkg::ctrl_t i_ctrl
);

    int fail_count = 0;

    // A load-use hazard costs a single bubble
    stall_single: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_stall |=> !i_stall)
        else begin
            fail_count++;
            $error("o_stall held for two cycles in a row");
        end

    ctrl_clear_after_reset: assert property (@(posedge i_clk)
        $rose(i_rst_n) |=> i_ctrl == '0)  // First ID/EX after release is a bubble
        else begin
            fail_count++;
            $error("ID/EX ctrl not zero one cycle after reset release");
        end

endmodule

bind mips_decode mips_tb_properties u_props (
    .i_clk   (i_clk),
    .i_rst_n (i_rst_n),
    .i_stall (o_stall),
    .i_ctrl  (o_id_ex.ctrl)
);

`default_nettype wire

/* hdl/mips_decode.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_decode (
    input  wire logic                   i_clk,
    input  wire logic                   i_rst_n,
    input  wire mips_pipe_pkg::if_id_t  i_if_id,
    input  wire mips_pipe_pkg::mem_wb_t i_mem_wb,
    input  wire logic                   i_branch_taken,
    output logic                        o_stall,
    output mips_pipe_pkg::id_ex_t       o_id_ex,
    output mips_pipe_pkg::wb_t          o_wb
);

    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    instr_u          instr;
    ctrl_t           ctrl;
    logic [XLEN-1:0] regs [0:(1<<REG_AW)-1];
    logic [XLEN-1:0] rs_data;
    logic [XLEN-1:0] rt_data;
    logic [XLEN-1:0] imm;

    assign instr = i_if_id.instr;
    assign imm   = {{(XLEN-16){instr.i.imm[15]}}, instr.i.imm};

    //////////////////////////////////////////////////////////////////////
    // Main control
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        ctrl = '0;
        case (instr.r.opcode)
            OP_RTYPE: begin
                ctrl.reg_write = 1'b1;
                ctrl.reg_dst   = 1'b1;
                case (instr.r.funct)
                    F_ADD:   ctrl.alu_op = ALU_ADD;
                    F_SUB:   ctrl.alu_op = ALU_SUB;
                    F_AND:   ctrl.alu_op = ALU_AND;
                    F_OR:    ctrl.alu_op = ALU_OR;
                    F_SLT:   ctrl.alu_op = ALU_SLT;
                    default: ctrl = '0;  // Unsupported funct, no-op
                endcase
            end
            OP_ADDI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            OP_LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.mem_read   = 1'b1;
                ctrl.alu_src    = 1'b1;
            end
            OP_SW: begin
                ctrl.mem_write = 1'b1;
                ctrl.alu_src   = 1'b1;
            end
            OP_BEQ: begin
                ctrl.branch = 1'b1;
                ctrl.alu_op = ALU_SUB;  // zero flag means equal
            end
            default: ;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // Write back and register file
    //////////////////////////////////////////////////////////////////////

    assign o_wb.we   = i_mem_wb.ctrl.reg_write && (i_mem_wb.dest != '0);
    assign o_wb.dest = i_mem_wb.dest;
    assign o_wb.data = i_mem_wb.ctrl.mem_to_reg ? i_mem_wb.read_data : i_mem_wb.alu_result;

    always_ff @(posedge i_clk) begin
        if (o_wb.we) begin
            regs[o_wb.dest] <= o_wb.data;
        end
    end

    // r0 reads zero, same-cycle write is bypassed
    assign rs_data = (instr.r.rs == '0) ? '0 :
                     (o_wb.we && o_wb.dest == instr.r.rs) ? o_wb.data : regs[instr.r.rs];
    assign rt_data = (instr.r.rt == '0) ? '0 :
                     (o_wb.we && o_wb.dest == instr.r.rt) ? o_wb.data : regs[instr.r.rt];

    // Load-use hazard
    assign o_stall = o_id_ex.ctrl.mem_read &&
                     (o_id_ex.rt == instr.r.rs || o_id_ex.rt == instr.r.rt);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_id_ex <= '0;
        end else begin
            o_id_ex.pc_plus4 <= i_if_id.pc_plus4;
            o_id_ex.rs_data  <= rs_data;
            o_id_ex.rt_data  <= rt_data;
            o_id_ex.imm      <= imm;
            o_id_ex.rs       <= instr.r.rs;
            o_id_ex.rt       <= instr.r.rt;
            o_id_ex.rd       <= instr.r.rd;
            if (o_stall || i_branch_taken) begin
                o_id_ex.ctrl <= '0;  // Bubble
            end else begin
                o_id_ex.ctrl <= ctrl;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/mips_execute.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_execute (
    input  wire logic                  i_clk,
    input  wire logic                  i_rst_n,
    input  wire mips_pipe_pkg::id_ex_t i_id_ex,
    input  wire logic [1:0]            i_fwd_a,
    input  wire logic [1:0]            i_fwd_b,
    input  wire mips_pipe_pkg::wb_t    i_wb,
    input  wire logic                  i_branch_taken,
    output mips_pipe_pkg::ex_mem_t     o_ex_mem
);

    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    logic [XLEN-1:0]   op_a;
    logic [XLEN-1:0]   rt_fwd;
    logic [XLEN-1:0]   op_b;
    logic [XLEN-1:0]   alu_y;
    logic [XLEN-1:0]   branch_target;
    logic [REG_AW-1:0] dest;

    function automatic logic [XLEN-1:0] fwd_mux(
        input logic [1:0]      sel,
        input logic [XLEN-1:0] rf_data,
        input logic [XLEN-1:0] exm_data,
        input logic [XLEN-1:0] wb_data
    );
        case (sel)
            FWD_EXMEM: return exm_data;
            FWD_WB:    return wb_data;
            default:   return rf_data;
        endcase
    endfunction

    assign op_a   = fwd_mux(i_fwd_a, i_id_ex.rs_data, o_ex_mem.alu_result, i_wb.data);
    assign rt_fwd = fwd_mux(i_fwd_b, i_id_ex.rt_data, o_ex_mem.alu_result, i_wb.data);
    assign op_b   = i_id_ex.ctrl.alu_src ? i_id_ex.imm : rt_fwd;

    //////////////////////////////////////////////////////////////////////
    // ALU
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (i_id_ex.ctrl.alu_op)
            ALU_SUB: alu_y = op_a - op_b;
            ALU_AND: alu_y = op_a & op_b;
            ALU_OR:  alu_y = op_a | op_b;
            ALU_SLT: alu_y = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            default: alu_y = op_a + op_b;
        endcase
    end

    assign branch_target = i_id_ex.pc_plus4 + {i_id_ex.imm[XLEN-3:0], 2'b00};
    assign dest          = i_id_ex.ctrl.reg_dst ? i_id_ex.rd : i_id_ex.rt;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_ex_mem <= '0;
        end else begin
            o_ex_mem.branch_target <= branch_target;
            o_ex_mem.alu_result    <= alu_y;
            o_ex_mem.zero          <= (alu_y == '0);
            o_ex_mem.store_data    <= rt_fwd;  // Forwarded, not the stale rt_data
            o_ex_mem.dest          <= dest;
            if (i_branch_taken) begin
                o_ex_mem.ctrl <= '0;
            end else begin
                o_ex_mem.ctrl <= i_id_ex.ctrl;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/mips_fetch.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_fetch (
    input  wire logic                          i_clk,
    input  wire logic                          i_rst_n,
    input  wire mips_pipe_pkg::imem_load_t     i_load,
    input  wire logic                          i_stall,
    input  wire logic                          i_branch_taken,
    input  wire logic [mips_isa_pkg::XLEN-1:0] i_branch_target,
    output logic [mips_isa_pkg::XLEN-1:0]      o_pc,
    output mips_pipe_pkg::if_id_t              o_if_id
);

    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    logic [XLEN-1:0] imem [0:(1<<IMEM_AW)-1];
    logic [XLEN-1:0] pc_plus4;
    logic [XLEN-1:0] instr;

    // Program load port, active in reset as well
    always_ff @(posedge i_clk) begin
        if (i_load.we) begin
            imem[i_load.addr] <= i_load.data;
        end
    end

    assign instr    = imem[o_pc[IMEM_AW+1:2]];  // Word addressed
    assign pc_plus4 = o_pc + XLEN'(4);

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_pc <= '0;
        end else if (i_branch_taken) begin
            o_pc <= i_branch_target;
        end else if (!i_stall) begin
            o_pc <= pc_plus4;
        end
    end

    // IF/ID, the flush wins over a stall
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_if_id <= '0;
        end else if (i_branch_taken) begin
            o_if_id <= '0;  // All-zero word is a no-op
        end else if (!i_stall) begin
            o_if_id.pc_plus4 <= pc_plus4;
            o_if_id.instr    <= instr;
        end
    end

endmodule

`default_nettype wire

/* hdl/mips_forward.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_forward (
    input  wire mips_pipe_pkg::id_ex_t  i_id_ex,
    input  wire mips_pipe_pkg::ex_mem_t i_ex_mem,
    input  wire mips_pipe_pkg::wb_t     i_wb,
    output logic [1:0]                  o_fwd_a,
    output logic [1:0]                  o_fwd_b
);

    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    // Newest producer first
    function automatic logic [1:0] fwd_sel(
        input logic [REG_AW-1:0] src,
        input ex_mem_t           ex_mem,
        input wb_t               wb
    );
        if (src == '0) begin
            return FWD_RF;
        end else if (ex_mem.ctrl.reg_write && ex_mem.dest == src) begin
            return FWD_EXMEM;
        end else if (wb.we && wb.dest == src) begin
            return FWD_WB;
        end
        return FWD_RF;
    endfunction

    assign o_fwd_a = fwd_sel(i_id_ex.rs, i_ex_mem, i_wb);
    assign o_fwd_b = fwd_sel(i_id_ex.rt, i_ex_mem, i_wb);

endmodule

`default_nettype wire

/* hdl/mips_isa_pkg.sv */
`default_nettype none

package mips_isa_pkg;

    localparam int XLEN   = 32;
    localparam int REG_AW = 5;

    //////////////////////////////////////////////////////////////////////
    // Encodings
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_BEQ   = 6'h04,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcode_e;

    typedef enum logic [5:0] {
        F_ADD = 6'h20,
        F_SUB = 6'h22,
        F_AND = 6'h24,
        F_OR  = 6'h25,
        F_SLT = 6'h2a
    } funct_e;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,  // Also the value of a cleared ctrl
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } alu_op_e;

    //////////////////////////////////////////////////////////////////////
    // Instruction formats
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [5:0]        opcode;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [REG_AW-1:0] rd;
        logic [4:0]        shamt;  // Unused, no shifts
        logic [5:0]        funct;
    } r_fmt_t;

    typedef struct packed {
        logic [5:0]        opcode;
        logic [REG_AW-1:0] rs;
        logic [REG_AW-1:0] rt;
        logic [15:0]       imm;
    } i_fmt_t;

    // Same fetched word, seen as R or I format
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

endpackage

`default_nettype wire

/* hdl/mips_memory.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_memory (
    input  wire logic                   i_clk,
    input  wire logic                   i_rst_n,
    input  wire mips_pipe_pkg::ex_mem_t i_ex_mem,
    output logic                        o_branch_taken,
    output logic [mips_isa_pkg::XLEN-1:0] o_branch_target,
    output mips_pipe_pkg::mem_wb_t      o_mem_wb
);

    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    logic [XLEN-1:0]    dmem [0:(1<<DMEM_AW)-1];
    logic [DMEM_AW-1:0] addr;
    logic [XLEN-1:0]    read_data;

    assign addr      = i_ex_mem.alu_result[DMEM_AW+1:2];  // Word index
    assign read_data = dmem[addr];

    always_ff @(posedge i_clk) begin
        if (i_ex_mem.ctrl.mem_write) begin
            dmem[addr] <= i_ex_mem.store_data;
        end
    end

    // beq resolves here
    assign o_branch_taken  = i_ex_mem.ctrl.branch && i_ex_mem.zero;
    assign o_branch_target = i_ex_mem.branch_target;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_mem_wb <= '0;
        end else begin
            o_mem_wb.ctrl       <= i_ex_mem.ctrl;
            o_mem_wb.alu_result <= i_ex_mem.alu_result;
            o_mem_wb.read_data  <= read_data;
            o_mem_wb.dest       <= i_ex_mem.dest;
        end
    end

endmodule

`default_nettype wire

/* hdl/mips_pipe_pkg.sv */
`default_nettype none

package mips_pipe_pkg;

    localparam int IMEM_AW = 6;  // 64 words
    localparam int DMEM_AW = 6;

    // Operand source select from the forwarding unit
    localparam logic [1:0] FWD_RF    = 2'd0;
    localparam logic [1:0] FWD_WB    = 2'd1;
    localparam logic [1:0] FWD_EXMEM = 2'd2;

    typedef struct packed {
        logic                  reg_write;
        logic                  mem_to_reg;
        logic                  mem_read;
        logic                  mem_write;
        logic                  branch;
        logic                  alu_src;   // Immediate as operand B
        logic                  reg_dst;   // rd instead of rt
        mips_isa_pkg::alu_op_e alu_op;
    } ctrl_t;

    //////////////////////////////////////////////////////////////////////
    // Stage latches
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic [mips_isa_pkg::XLEN-1:0] pc_plus4;
        mips_isa_pkg::instr_u          instr;
    } if_id_t;

    typedef struct packed {
        ctrl_t                           ctrl;
        logic [mips_isa_pkg::XLEN-1:0]   pc_plus4;
        logic [mips_isa_pkg::XLEN-1:0]   rs_data;
        logic [mips_isa_pkg::XLEN-1:0]   rt_data;
        logic [mips_isa_pkg::XLEN-1:0]   imm;
        logic [mips_isa_pkg::REG_AW-1:0] rs;
        logic [mips_isa_pkg::REG_AW-1:0] rt;
        logic [mips_isa_pkg::REG_AW-1:0] rd;
    } id_ex_t;

    typedef struct packed {
        ctrl_t                           ctrl;
        logic [mips_isa_pkg::XLEN-1:0]   branch_target;
        logic [mips_isa_pkg::XLEN-1:0]   alu_result;
        logic                            zero;
        logic [mips_isa_pkg::XLEN-1:0]   store_data;
        logic [mips_isa_pkg::REG_AW-1:0] dest;
    } ex_mem_t;

    typedef struct packed {
        ctrl_t                           ctrl;
        logic [mips_isa_pkg::XLEN-1:0]   alu_result;
        logic [mips_isa_pkg::XLEN-1:0]   read_data;
        logic [mips_isa_pkg::REG_AW-1:0] dest;
    } mem_wb_t;

    //////////////////////////////////////////////////////////////////////
    // Ports
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                            we;
        logic [mips_isa_pkg::REG_AW-1:0] dest;
        logic [mips_isa_pkg::XLEN-1:0]   data;
    } wb_t;

    typedef struct packed {
        logic                          we;
        logic [IMEM_AW-1:0]            addr;
        logic [mips_isa_pkg::XLEN-1:0] data;
    } imem_load_t;

endpackage

`default_nettype wire

/* hdl/mips_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mips_top (
    input  wire logic                      i_clk,
    input  wire logic                      i_rst_n,
    input  wire mips_pipe_pkg::imem_load_t i_load,
    output mips_pipe_pkg::wb_t             o_wb,
    output logic [mips_isa_pkg::XLEN-1:0]  o_pc
);

    import mips_isa_pkg::*;
    import mips_pipe_pkg::*;

    if_id_t          if_id;
    id_ex_t          id_ex;
    ex_mem_t         ex_mem;
    mem_wb_t         mem_wb;
    logic            stall;
    logic            branch_taken;
    logic [XLEN-1:0] branch_target;
    logic [1:0]      fwd_a;
    logic [1:0]      fwd_b;

    //////////////////////////////////////////////////////////////////////
    // Pipeline stages
    //////////////////////////////////////////////////////////////////////

    mips_fetch u_fetch (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_load          (i_load),
        .i_stall         (stall),
        .i_branch_taken  (branch_taken),
        .i_branch_target (branch_target),
        .o_pc            (o_pc),
        .o_if_id         (if_id)
    );

    mips_decode u_decode (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_if_id        (if_id),
        .i_mem_wb       (mem_wb),
        .i_branch_taken (branch_taken),
        .o_stall        (stall),
        .o_id_ex        (id_ex),
        .o_wb           (o_wb)  // Also feeds forwarding
    );

    mips_forward u_forward (
        .i_id_ex  (id_ex),
        .i_ex_mem (ex_mem),
        .i_wb     (o_wb),
        .o_fwd_a  (fwd_a),
        .o_fwd_b  (fwd_b)
    );

    mips_execute u_execute (
        .i_clk          (i_clk),
        .i_rst_n        (i_rst_n),
        .i_id_ex        (id_ex),
        .i_fwd_a        (fwd_a),
        .i_fwd_b        (fwd_b),
        .i_wb           (o_wb),
        .i_branch_taken (branch_taken),
        .o_ex_mem       (ex_mem)
    );

    mips_memory u_memory (
        .i_clk           (i_clk),
        .i_rst_n         (i_rst_n),
        .i_ex_mem        (ex_mem),
        .o_branch_taken  (branch_taken),
        .o_branch_target (branch_target),
        .o_mem_wb        (mem_wb)
    );

endmodule

`default_nettype wire

/* list.f */
hdl/mips_isa_pkg.sv
hdl/mips_pipe_pkg.sv
hdl/mips_fetch.sv
hdl/mips_decode.sv
hdl/mips_forward.sv
hdl/mips_execute.sv
hdl/mips_memory.sv
hdl/mips_top.sv
bench/mips_tb_properties.sv
bench/mips_tb.sv
